//--- dv/tm1637_cases.txt
// Columns: ack (1 pulls DIO low in ack slots), delay ticks from the previous stop,
// byte count, byte 0, byte 1 (00 when unused), nack_error expected after the frame.
// Frame 2 waits 0 ticks because its step delay runs while frame 1 is still shifting.
01 01 01 40 00 00
01 00 02 C0 06 00
00 03 02 C0 06 01
01 03 02 C0 06 01
01 02 01 8F 00 01

//--- dv/tm1637_tb.sv
// Testbench for the TM1637 sequencer with ack responder, bus decoder and frame checks.
`timescale 1ns/1ps

module tm1637_tb;

    localparam int tick_div     = 8;     // Short tick for simulation.
    localparam int reset_cycles = 3;
    localparam int frame_limit  = 2000;  // Cycles allowed per frame.
    localparam int halt_cycles  = 2000;
    localparam int max_frames   = 8;
    localparam int rec_words    = 6;     // Words per line of the cases file.
    localparam int col_ack      = 0;
    localparam int col_delay    = 1;
    localparam int col_count    = 2;
    localparam int col_byte0    = 3;
    localparam int col_nack     = 5;

    logic clk_50M;
    logic rst_n;
    logic tm1637_dio_in = 1'b1;  // Released line.
    logic tm1637_clk;
    logic tm1637_dio;
    logic nack_error;

    logic [7:0] case_mem [max_frames*rec_words];
    int         n_frames;
    int         errors = 0;
    int         checks = 0;
    logic       timed_out;

    // Bus decoder state.
    logic       in_reset;    // Reset as the DUT saw it on this edge.
    logic       clk_q;
    logic       dio_q;
    logic       in_frame;
    logic       seen_start;
    logic       ack_drive;   // Responder pulls DIO low.
    int         bit_cnt;     // Clock rises inside the current byte.
    logic [7:0] rx_byte;
    logic [7:0] rx_q [$];    // Bytes of the open frame.
    int         frames_done = 0;
    int         edge_count = 0;
    longint     cycle_cnt = 0;
    longint     idle_from = 0;  // Cycle of the last stop or reset.

    tm1637_top #(.tick_div(tick_div)) tm1637_top_i (
        .clk_50M       (clk_50M),
        .rst_n         (rst_n),
        .tm1637_dio_in (tm1637_dio_in),
        .tm1637_clk    (tm1637_clk),
        .tm1637_dio    (tm1637_dio),
        .nack_error    (nack_error)
    );

    initial begin
        clk_50M = 1'b0;
        forever #2 clk_50M = ~clk_50M;  // 4 ns period.
    end

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Fail at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error at %0t ns: %s.", $time, what);
        end
    endtask

    function automatic int case_field(input int frame, input int col);
        if (frame >= n_frames) return 0;  // Beyond the list.
        return int'(case_mem[frame*rec_words + col]);
    endfunction

    // Marks words the cases file leaves unread, well above any byte count.
    function automatic logic [7:0] fill_word(input int addr);
        return 8'hFF ^ addr[7:0];
    endfunction

    task automatic load_cases();
        for (int i = 0; i < max_frames*rec_words; i++) case_mem[i] = fill_word(i);
        $readmemh("dv/tm1637_cases.txt", case_mem);
        n_frames = 0;
        while (n_frames < max_frames &&
               case_mem[n_frames*rec_words + col_count]
                   != fill_word(n_frames*rec_words + col_count))
            n_frames++;
        check_true(n_frames > 0, "no frames read from the cases file");
    endtask

    task automatic check_idle_bus();
        check_value("tm1637_clk", int'(tm1637_clk), 1);
        check_value("tm1637_dio", int'(tm1637_dio), 1);
        check_value("nack_error", int'(nack_error), 0);
    endtask

    task automatic open_frame();
        longint gap;
        gap = cycle_cnt - idle_from;
        check_true(!in_frame, "start condition inside an open frame");
        check_true(frames_done < n_frames, "more frames on the bus than the cases file lists");
        check_true(gap >= longint'(case_field(frames_done, col_delay) * tick_div),
                   "frame started before its step delay ran out");
        seen_start = 1'b1;
        in_frame   = 1'b1;
        bit_cnt    = 0;
        ack_drive  = 1'b0;
        rx_q.delete();
    endtask

    task automatic close_frame();
        int count;
        count = case_field(frames_done, col_count);
        check_true(in_frame, "stop condition without an open frame");
        check_true(bit_cnt <= 1, "stop condition inside a byte");  // One rise is the stop clock.
        check_value("frame byte count", rx_q.size(), count);
        for (int i = 0; i < count && i < rx_q.size(); i++) begin
            check_value($sformatf("tm1637_dio byte %0d of frame %0d", i, frames_done),
                        int'(rx_q[i]), case_field(frames_done, col_byte0 + i));
        end
        check_value("nack_error", int'(nack_error), case_field(frames_done, col_nack));
        in_frame  = 1'b0;
        bit_cnt   = 0;
        idle_from = cycle_cnt;
        frames_done++;
    endtask

    task automatic decode_bus();
        logic clk_hold;
        logic start_now;
        logic stop_now;
        clk_hold  = clk_q && tm1637_clk;
        start_now = clk_hold && dio_q && !tm1637_dio;  // DIO falls under a high clock.
        stop_now  = clk_hold && !dio_q && tm1637_dio;  // DIO rises under a high clock.
        if (tm1637_clk !== clk_q || tm1637_dio !== dio_q) edge_count++;
        if (!seen_start && !start_now) check_idle_bus();
        if (start_now) begin
            open_frame();
        end else if (stop_now) begin
            close_frame();
        end else if (!clk_q && tm1637_clk) begin
            check_true(in_frame, "clock pulse outside a frame");
            if (bit_cnt < 8) rx_byte[bit_cnt] = tm1637_dio;  // LSB first.
            bit_cnt++;
        end else if (clk_q && !tm1637_clk) begin
            if (bit_cnt == 8) begin
                ack_drive = (case_field(frames_done, col_ack) != 0);  // Ack slot opens.
            end else if (bit_cnt == 9) begin
                rx_q.push_back(rx_byte);  // Ack clock done so the byte is complete.
                bit_cnt   = 0;
                ack_drive = 1'b0;
            end
        end
        clk_q = tm1637_clk;
        dio_q = tm1637_dio;
    endtask

    // Decoder and responder sample just after each edge.
    always @(posedge clk_50M) begin
        in_reset = !rst_n;
        #1;
        cycle_cnt++;
        if (in_reset) begin
            clk_q      = 1'b1;
            dio_q      = 1'b1;
            in_frame   = 1'b0;
            seen_start = 1'b0;
            ack_drive  = 1'b0;
            bit_cnt    = 0;
            idle_from  = cycle_cnt;
            check_idle_bus();
        end else begin
            decode_bus();
        end
        tm1637_dio_in = ack_drive ? 1'b0 : tm1637_dio;  // Otherwise mirror the line.
    end

    task automatic wait_for_frames(input int target);
        int waited;
        waited = 0;
        while (frames_done < target && waited < frame_limit) begin
            @(posedge clk_50M);
            waited++;
        end
        timed_out = (frames_done < target);
        check_true(!timed_out, "timed out waiting for a frame to end");
    endtask

    task automatic check_quiet_after_halt();
        int edges_before;
        int waited;
        edges_before = edge_count;
        waited = 0;
        while (waited < halt_cycles && edge_count == edges_before) begin
            @(posedge clk_50M);
            waited++;
        end
        check_true(edge_count == edges_before, "bus moved after the halt step");
        check_value("frames decoded", frames_done, n_frames);
    endtask

    initial begin
        rst_n     = 1'b0;
        timed_out = 1'b0;
        load_cases();
        repeat (reset_cycles) @(posedge clk_50M);
        #1 rst_n = 1'b1;
        for (int f = 1; f <= n_frames && !timed_out; f++) begin
            wait_for_frames(f);
        end
        if (!timed_out) check_quiet_after_halt();
        $display("Checks: %0d, errors: %0d, frames decoded: %0d", checks, errors, frames_done);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/tm1637_pkg.sv
verilog/tick_gen.sv
verilog/step_rom.sv
verilog/step_sequencer.sv
verilog/tm1637_writer.sv
verilog/tm1637_top.sv
dv/tm1637_tb.sv

//--- run.sh
#!/bin/sh
# Build the TM1637 testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tm1637_tb -f filelist.f -o tm1637_sim

if ! ./obj_dir/tm1637_sim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status."
    exit 1
fi
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- verilog/step_rom.sv
// Step ROM holding the display command program as a registered table.
`timescale 1ns/1ps

module step_rom (
    input  logic                   clk_50M,
    input  tm1637_pkg::step_addr_t addr,
    output tm1637_pkg::step_word_t step
);

    // Packs the fields at the positions the sequencer decodes.
    function automatic tm1637_pkg::step_word_t pack_step(
        input tm1637_pkg::step_op_t op,
        input logic                 backward,
        input tm1637_pkg::jump_t    offset,
        input logic                 last,
        input logic                 wait_flag,
        input tm1637_pkg::repeat_t  count,
        input tm1637_pkg::delay_t   delay,
        input tm1637_pkg::tx_byte_t data
    );
        tm1637_pkg::step_word_t w;
        w = '0;
        w[tm1637_pkg::op_lsb +: 2]                                = op;
        w[tm1637_pkg::backward_bit]                               = backward;
        w[tm1637_pkg::offset_lsb +: $bits(tm1637_pkg::jump_t)]    = offset;
        w[tm1637_pkg::last_bit]                                   = last;
        w[tm1637_pkg::wait_bit]                                   = wait_flag;
        w[tm1637_pkg::count_lsb +: $bits(tm1637_pkg::repeat_t)]   = count;
        w[tm1637_pkg::delay_lsb +: $bits(tm1637_pkg::delay_t)]    = delay;
        w[tm1637_pkg::data_lsb +: $bits(tm1637_pkg::tx_byte_t)]   = data;
        return w;
    endfunction

    always_ff @(posedge clk_50M) begin
        case (addr)
            // Data command, auto increment.
            4'd0: step <= pack_step(tm1637_pkg::op_write, 1'b0, 3'd0, 1'b1, 1'b0,
                                    4'd0, 16'd1, 8'h40);
            // Two extra passes over steps 2 to 4.
            4'd1: step <= pack_step(tm1637_pkg::op_loop, 1'b0, 3'd0, 1'b0, 1'b0,
                                    4'd2, 16'd0, 8'h00);
            // Address command for digit 0.
            4'd2: step <= pack_step(tm1637_pkg::op_write, 1'b0, 3'd0, 1'b0, 1'b0,
                                    4'd0, 16'd3, 8'hC0);
            4'd3: step <= pack_step(tm1637_pkg::op_write, 1'b0, 3'd0, 1'b1, 1'b1,
                                    4'd0, 16'd0, 8'h06);  // Segments of "1".
            4'd4: step <= pack_step(tm1637_pkg::op_jump, 1'b1, 3'd2, 1'b0, 1'b0,
                                    4'd0, 16'd0, 8'h00);  // Back to step 2.
            // Display on, full brightness.
            4'd5: step <= pack_step(tm1637_pkg::op_write, 1'b0, 3'd0, 1'b1, 1'b1,
                                    4'd0, 16'd2, 8'h8F);
            default: step <= pack_step(tm1637_pkg::op_halt, 1'b0, 3'd0, 1'b0, 1'b0,
                                       4'd0, 16'd0, 8'h00);  // Step 6 and unused.
        endcase
    end

endmodule

//--- verilog/step_sequencer.sv
// Step sequencer that fetches, delays and executes ROM steps and feeds the writer.
`timescale 1ns/1ps

module step_sequencer (
    input  logic                   clk_50M,
    input  logic                   rst_n,
    input  logic                   tick,
    input  tm1637_pkg::step_word_t step,
    input  logic                   byte_ready,
    input  logic                   writer_idle,
    output tm1637_pkg::step_addr_t addr,
    output logic                   byte_valid,
    output tm1637_pkg::tx_byte_t   byte_data,
    output logic                   byte_last
);

    typedef enum logic [2:0] {
        st_fetch,   // ROM read in flight.
        st_delay,   // Counting ticks.
        st_send,    // Byte offered to the writer.
        st_drain,   // Waiting for the frame to finish.
        st_halted
    } seq_state_t;

    seq_state_t state;

    // Decoded fields of the current step.
    tm1637_pkg::step_op_t op;
    logic                 step_backward;
    tm1637_pkg::jump_t    step_offset;
    logic                 step_last;
    logic                 step_wait;
    tm1637_pkg::repeat_t  step_count;
    tm1637_pkg::delay_t   step_delay;
    tm1637_pkg::tx_byte_t step_data;

    assign op            = tm1637_pkg::step_op_t'(step[tm1637_pkg::op_lsb +: 2]);
    assign step_backward = step[tm1637_pkg::backward_bit];
    assign step_offset   = step[tm1637_pkg::offset_lsb +: $bits(tm1637_pkg::jump_t)];
    assign step_last     = step[tm1637_pkg::last_bit];
    assign step_wait     = step[tm1637_pkg::wait_bit];
    assign step_count    = step[tm1637_pkg::count_lsb +: $bits(tm1637_pkg::repeat_t)];
    assign step_delay    = step[tm1637_pkg::delay_lsb +: $bits(tm1637_pkg::delay_t)];
    assign step_data     = step[tm1637_pkg::data_lsb +: $bits(tm1637_pkg::tx_byte_t)];

    tm1637_pkg::repeat_t repeat_cnt;  // Passes left in the open loop.
    tm1637_pkg::delay_t  delay_cnt;   // Whole ticks counted so far.
    logic                synced;      // First tick seen, period boundary found.
    logic                delay_done;

    assign delay_done = (delay_cnt == step_delay);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            state      <= st_fetch;
            addr       <= '0;
            byte_valid <= 1'b0;
            repeat_cnt <= '0;
            delay_cnt  <= '0;
            synced     <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    delay_cnt <= '0;
                    synced    <= 1'b0;
                    state     <= st_delay;  // Step word valid from here on.
                end
                st_delay: begin
                    if (delay_done) begin
                        case (op)
                            tm1637_pkg::op_write: begin
                                byte_valid <= 1'b1;
                                state      <= st_send;
                            end
                            tm1637_pkg::op_loop: begin
                                repeat_cnt <= step_count;
                                addr       <= addr + 1'b1;
                                state      <= st_fetch;
                            end
                            tm1637_pkg::op_jump: begin
                                if (repeat_cnt != '0) begin
                                    repeat_cnt <= repeat_cnt - 1'b1;
                                    addr <= step_backward ? addr - {1'b0, step_offset}
                                                          : addr + {1'b0, step_offset};
                                end else begin
                                    addr <= addr + 1'b1;  // Loop spent, fall through.
                                end
                                state <= st_fetch;
                            end
                            default: state <= st_halted;
                        endcase
                    end else if (tick) begin
                        // First tick only aligns to a whole tick period.
                        if (synced) delay_cnt <= delay_cnt + 1'b1;
                        synced <= 1'b1;
                    end
                end
                st_send: begin
                    if (byte_ready) begin
                        byte_valid <= 1'b0;
                        if (step_wait) begin
                            state <= st_drain;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= st_fetch;
                        end
                    end
                end
                st_drain: begin
                    if (writer_idle) begin
                        addr  <= addr + 1'b1;
                        state <= st_fetch;
                    end
                end
                default: ;  // Halted, nothing moves.
            endcase
        end
    end

    // Byte payload, latched as the write step fires.
    always_ff @(posedge clk_50M) begin
        if (state == st_delay && delay_done && op == tm1637_pkg::op_write) begin
            byte_data <= step_data;
            byte_last <= step_last;
        end
    end

    assert property (@(posedge clk_50M) disable iff (!rst_n)
        byte_valid && !byte_ready |=> byte_valid && $stable(byte_data))
        else $error("byte dropped or changed before the handshake");

    assert property (@(posedge clk_50M) disable iff (!rst_n)
        state == st_halted |=> $stable(addr))
        else $error("step index moved after halt");

endmodule

//--- verilog/tick_gen.sv
// Tick generator that divides the system clock into a one-cycle step tick.
`timescale 1ns/1ps

module tick_gen #(
    parameter int tick_div = tm1637_pkg::tick_div_default
) (
    input  logic clk_50M,
    input  logic rst_n,
    output logic tick
);

    localparam int cnt_w = $clog2(tick_div);

    logic [cnt_w-1:0] cnt;  // Counts down to zero.

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            cnt  <= cnt_w'(tick_div - 1);
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= cnt_w'(tick_div - 1);  // Reload for the next period.
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // A tick is a single-cycle strobe, or the sequencer would count it twice.
    assert property (@(posedge clk_50M) disable iff (!rst_n) tick |=> !tick)
        else $error("tick held high for two cycles");

endmodule

//--- verilog/tm1637_pkg.sv
// TM1637 sequencer package with step encoding, field positions and default timing.
package tm1637_pkg;

    localparam int step_addr_w = 4;  // ROM depth of 16 steps.

    typedef logic [step_addr_w-1:0] step_addr_t;  // Step index.
    typedef logic [35:0]            step_word_t;  // One encoded step.
    typedef logic [7:0]             tx_byte_t;    // Display byte.
    typedef logic [15:0]            delay_t;      // Delay in ticks.
    typedef logic [3:0]             repeat_t;     // Loop count.
    typedef logic [2:0]             jump_t;       // Jump offset.

    // Step operations.
    typedef enum logic [1:0] {
        op_write = 2'd0,  // Send one byte.
        op_loop  = 2'd1,  // Load the repeat count.
        op_jump  = 2'd2,  // Jump while the count lasts.
        op_halt  = 2'd3   // Stop for good.
    } step_op_t;

    // Field positions inside step_word_t, from the top bit down.
    localparam int op_lsb       = 34;  // [35:34] Operation.
    localparam int backward_bit = 33;  // Jump direction, 1 is backward.
    localparam int offset_lsb   = 30;  // [32:30] Jump offset.
    localparam int last_bit     = 29;  // Byte closes the frame.
    localparam int wait_bit     = 28;  // Hold until the writer is idle.
    localparam int count_lsb    = 24;  // [27:24] Loop count.
    localparam int delay_lsb    = 8;   // [23:8] Delay before the step.
    localparam int data_lsb     = 0;   // [7:0] Byte to send.

    // Timing defaults.
    localparam int tick_div_default = 25_000_000;  // Half a second per tick at 50 MHz.
    localparam int bit_half_cycles  = 4;           // Clock cycles per bus phase.

endpackage

//--- verilog/tm1637_top.sv
// TM1637 display top level joining tick generator, step ROM, sequencer and writer.
`timescale 1ns/1ps

module tm1637_top #(
    parameter int tick_div = tm1637_pkg::tick_div_default
) (
    input  logic clk_50M,
    input  logic rst_n,
    input  logic tm1637_dio_in,   // Sampled DIO pin.
    output logic tm1637_clk,      // 1 releases CLK.
    output logic tm1637_dio,      // 1 releases DIO.
    output logic nack_error
);

    logic                   tick;
    tm1637_pkg::step_addr_t addr;
    tm1637_pkg::step_word_t step;
    logic                   byte_valid;
    logic                   byte_ready;
    tm1637_pkg::tx_byte_t   byte_data;
    logic                   byte_last;
    logic                   writer_idle;

    tick_gen #(.tick_div(tick_div)) tick_gen_i (
        .clk_50M (clk_50M),
        .rst_n   (rst_n),
        .tick    (tick)
    );

    step_rom step_rom_i (
        .clk_50M (clk_50M),
        .addr    (addr),
        .step    (step)
    );

    step_sequencer step_sequencer_i (
        .clk_50M     (clk_50M),
        .rst_n       (rst_n),
        .tick        (tick),
        .step        (step),
        .byte_ready  (byte_ready),
        .writer_idle (writer_idle),
        .addr        (addr),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_last   (byte_last)
    );

    tm1637_writer tm1637_writer_i (
        .clk_50M       (clk_50M),
        .rst_n         (rst_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .byte_last     (byte_last),
        .tm1637_dio_in (tm1637_dio_in),
        .byte_ready    (byte_ready),
        .writer_idle   (writer_idle),
        .tm1637_clk    (tm1637_clk),
        .tm1637_dio    (tm1637_dio),
        .nack_error    (nack_error)
    );

endmodule

//--- verilog/tm1637_writer.sv
// Two-wire TM1637 writer with start, LSB-first data, ack check and stop.
`timescale 1ns/1ps

module tm1637_writer (
    input  logic                 clk_50M,
    input  logic                 rst_n,
    input  logic                 byte_valid,
    input  tm1637_pkg::tx_byte_t byte_data,
    input  logic                 byte_last,
    input  logic                 tm1637_dio_in,
    output logic                 byte_ready,
    output logic                 writer_idle,
    output logic                 tm1637_clk,  // 1 releases the line.
    output logic                 tm1637_dio,  // 1 releases the line.
    output logic                 nack_error
);

    localparam int half_w = $clog2(tm1637_pkg::bit_half_cycles);

    typedef enum logic [3:0] {
        st_idle, st_start, st_bit_lo, st_bit_hi, st_ack_lo,
        st_ack_hi, st_gap, st_stop_lo, st_stop_hi
    } wr_state_t;

    wr_state_t            state;
    logic [half_w-1:0]    half_cnt;    // Cycles into the current phase.
    logic [2:0]           bit_cnt;     // Data bit being sent.
    tm1637_pkg::tx_byte_t shift;       // Next bit at bit 0.
    logic                 last_q;      // Current byte closes the frame.
    logic                 frame_open;  // Start done, stop still owed.
    logic                 phase_end;

    assign phase_end   = (half_cnt == half_w'(tm1637_pkg::bit_half_cycles - 1));
    assign byte_ready  = (state == st_idle);
    assign writer_idle = (state == st_idle) && !frame_open;

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            state      <= st_idle;
            half_cnt   <= '0;
            bit_cnt    <= '0;
            frame_open <= 1'b0;
            nack_error <= 1'b0;
            tm1637_clk <= 1'b1;
            tm1637_dio <= 1'b1;
        end else begin
            half_cnt <= (state == st_idle || phase_end) ? '0 : half_cnt + 1'b1;
            case (state)
                st_idle: begin
                    if (byte_valid) begin
                        bit_cnt <= '0;
                        state   <= frame_open ? st_bit_lo : st_start;  // Open frame skips start.
                    end
                end
                st_start: begin
                    tm1637_dio <= 1'b0;  // Falls with the clock high.
                    if (phase_end) begin
                        tm1637_clk <= 1'b0;
                        state      <= st_bit_lo;
                    end
                end
                st_bit_lo: begin
                    tm1637_dio <= shift[0];  // Data moves only with the clock low.
                    if (phase_end) begin
                        tm1637_clk <= 1'b1;
                        state      <= st_bit_hi;
                    end
                end
                st_bit_hi: begin
                    if (phase_end) begin
                        tm1637_clk <= 1'b0;
                        bit_cnt    <= bit_cnt + 1'b1;
                        state      <= (bit_cnt == 3'd7) ? st_ack_lo : st_bit_lo;
                    end
                end
                st_ack_lo: begin
                    tm1637_dio <= 1'b1;  // Release so the display can pull low.
                    if (phase_end) begin
                        tm1637_clk <= 1'b1;
                        state      <= st_ack_hi;
                    end
                end
                st_ack_hi: begin
                    if (half_cnt == '0 && tm1637_dio_in) nack_error <= 1'b1;  // Sticky.
                    if (phase_end) begin
                        tm1637_clk <= 1'b0;
                        state      <= last_q ? st_stop_lo : st_gap;
                    end
                end
                st_gap: begin
                    if (phase_end) begin
                        frame_open <= 1'b1;  // Clock parked low for the next byte.
                        state      <= st_idle;
                    end
                end
                st_stop_lo: begin
                    tm1637_dio <= 1'b0;
                    if (phase_end) begin
                        tm1637_clk <= 1'b1;
                        state      <= st_stop_hi;
                    end
                end
                default: begin  // Stop high.
                    if (phase_end) begin
                        tm1637_dio <= 1'b1;  // Rises with the clock high.
                        frame_open <= 1'b0;
                        state      <= st_idle;
                    end
                end
            endcase
        end
    end

    // Shift register and frame end flag.
    always_ff @(posedge clk_50M) begin
        if (state == st_idle && byte_valid) begin
            shift  <= byte_data;
            last_q <= byte_last;
        end else if (state == st_bit_hi && phase_end) begin
            shift <= shift >> 1;
        end
    end

    // Only start and stop may move DIO under a high clock.
    assert property (@(posedge clk_50M) disable iff (!rst_n)
        tm1637_clk && $past(tm1637_clk) && !$stable(tm1637_dio)
            |-> $past(state) inside {st_start, st_stop_hi})
        else $error("DIO changed while CLK high outside start or stop");

endmodule
